//--- logic/rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int num_regs = 32;
  localparam int reg_idx_bits = $clog2(num_regs);

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_idx_bits-1:0] reg_idx_t;

  // instruction ROM, word organised
  localparam int imem_words = 256;
  localparam int imem_idx_bits = $clog2(imem_words);
  localparam word_t reset_pc = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] op_lui     = 7'b01_101_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_branch  = 7'b11_000_11;
  localparam logic [6:0] op_system  = 7'b11_100_11;

  // funct7, alt selects sub and the arithmetic right shift
  localparam logic [6:0] funct7_base = 7'b000_0000;
  localparam logic [6:0] funct7_alt  = 7'b010_0000;

  // funct3 for the integer ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for the conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    none, eq, ne, lt, ge, ltu, geu
  } branch_cond_e;

  // control and operands for one instruction
  typedef struct packed {
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    alu_op_e      alu_op;
    logic         use_imm;
    branch_cond_e branch_cond;
    logic         reg_write;
    logic         halt_req;
    logic         illegal;
  } decoded_t;

  // one executed instruction as seen at the top level
  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    reg_idx_t rd;
    logic     reg_write;
    word_t    value;
    logic     halt;
  } retire_t;

endpackage

//--- logic/fetch_unit.sv
module fetch_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t next_pc,
  input  logic          halt,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t insn
);

  rv_pkg::word_t rom [rv_pkg::imem_words];
  logic [rv_pkg::imem_idx_bits-1:0] word_idx;

  initial begin
    $readmemh("sim/program.hex", rom);
  end

  // pc freezes once the core has halted
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::reset_pc;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  // byte address to word index, upper bits wrap inside the ROM
  assign word_idx = pc[rv_pkg::imem_idx_bits+1:2];
  assign insn = rom[word_idx];

  // branch targets come back from execute, so this checks the whole loop
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

//--- logic/insn_decoder.sv
module insn_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_u;
  rv_pkg::word_t imm_shamt;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_shamt = {27'd0, insn[24:20]};

  always_comb begin
    dec = '0;
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.rd = insn[11:7];
    dec.imm = imm_i;
    dec.alu_op = rv_pkg::add;
    dec.branch_cond = rv_pkg::none;

    case (opcode)
      rv_pkg::op_lui: begin
        dec.imm = imm_u;
        dec.alu_op = rv_pkg::pass_b;
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
      end
      rv_pkg::op_reg_imm: begin
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
        case (funct3)
          rv_pkg::f3_add_sub: dec.alu_op = rv_pkg::add;
          rv_pkg::f3_slt:     dec.alu_op = rv_pkg::slt;
          rv_pkg::f3_sltu:    dec.alu_op = rv_pkg::sltu;
          rv_pkg::f3_xor:     dec.alu_op = rv_pkg::xor_op;
          rv_pkg::f3_or:      dec.alu_op = rv_pkg::or_op;
          rv_pkg::f3_and:     dec.alu_op = rv_pkg::and_op;
          rv_pkg::f3_sll: begin
            dec.imm = imm_shamt;
            dec.alu_op = rv_pkg::sll;
            dec.illegal = (funct7 != rv_pkg::funct7_base);
          end
          default: begin
            // srli and srai share funct3, funct7 picks the fill
            dec.imm = imm_shamt;
            dec.alu_op = (funct7 == rv_pkg::funct7_alt) ? rv_pkg::sra : rv_pkg::srl;
            dec.illegal = (funct7 != rv_pkg::funct7_base) && (funct7 != rv_pkg::funct7_alt);
          end
        endcase
      end
      rv_pkg::op_reg_reg: begin
        dec.reg_write = 1'b1;
        case (funct3)
          rv_pkg::f3_add_sub: dec.alu_op = funct7[5] ? rv_pkg::sub : rv_pkg::add;
          rv_pkg::f3_sll:     dec.alu_op = rv_pkg::sll;
          rv_pkg::f3_slt:     dec.alu_op = rv_pkg::slt;
          rv_pkg::f3_sltu:    dec.alu_op = rv_pkg::sltu;
          rv_pkg::f3_xor:     dec.alu_op = rv_pkg::xor_op;
          rv_pkg::f3_srl_sra: dec.alu_op = funct7[5] ? rv_pkg::sra : rv_pkg::srl;
          rv_pkg::f3_or:      dec.alu_op = rv_pkg::or_op;
          default:            dec.alu_op = rv_pkg::and_op;
        endcase
        // alt form only exists for sub and sra
        if (funct7 == rv_pkg::funct7_alt) begin
          dec.illegal = (funct3 != rv_pkg::f3_add_sub) && (funct3 != rv_pkg::f3_srl_sra);
        end else begin
          dec.illegal = (funct7 != rv_pkg::funct7_base);
        end
      end
      rv_pkg::op_branch: begin
        dec.imm = imm_b;
        case (funct3)
          rv_pkg::f3_beq:  dec.branch_cond = rv_pkg::eq;
          rv_pkg::f3_bne:  dec.branch_cond = rv_pkg::ne;
          rv_pkg::f3_blt:  dec.branch_cond = rv_pkg::lt;
          rv_pkg::f3_bge:  dec.branch_cond = rv_pkg::ge;
          rv_pkg::f3_bltu: dec.branch_cond = rv_pkg::ltu;
          rv_pkg::f3_bgeu: dec.branch_cond = rv_pkg::geu;
          default:         dec.illegal = 1'b1;
        endcase
      end
      rv_pkg::op_system: begin
        // only ecall, every other field must be zero
        dec.halt_req = (insn[31:7] == 25'd0);
        dec.illegal = !dec.halt_req;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase

    // an illegal encoding retires as a no-op
    if (dec.illegal) begin
      dec.reg_write = 1'b0;
      dec.branch_cond = rv_pkg::none;
    end
  end

endmodule

//--- logic/reg_file.sv
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd,
  input  logic             wb_en,
  input  rv_pkg::word_t    wb_value
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  // x0 keeps its reset value because execute never enables a write to it
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[rd] <= wb_value;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  x0_zero_a: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0) |-> (rs1_data == '0)
  ) else $error("x0 read back nonzero: %h", rs1_data);

endmodule

//--- logic/exec_unit.sv
module exec_unit (
  input  rv_pkg::word_t    pc,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    next_pc,
  output logic             wb_en,
  output rv_pkg::word_t    wb_value,
  output logic             halt_req
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  logic [4:0] shamt;
  logic taken;

  assign op_a = rs1_data;
  assign op_b = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::add:    wb_value = op_a + op_b;
      rv_pkg::sub:    wb_value = op_a - op_b;
      rv_pkg::sll:    wb_value = op_a << shamt;
      rv_pkg::slt:    wb_value = {31'd0, $signed(op_a) < $signed(op_b)};
      // both sides unsigned here
      rv_pkg::sltu:   wb_value = {31'd0, op_a < op_b};
      rv_pkg::xor_op: wb_value = op_a ^ op_b;
      rv_pkg::srl:    wb_value = op_a >> shamt;
      rv_pkg::sra:    wb_value = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::or_op:  wb_value = op_a | op_b;
      rv_pkg::and_op: wb_value = op_a & op_b;
      default:        wb_value = op_b;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (dec.branch_cond)
      rv_pkg::eq:  taken = (rs1_data == rs2_data);
      rv_pkg::ne:  taken = (rs1_data != rs2_data);
      rv_pkg::lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::ltu: taken = (rs1_data < rs2_data);
      rv_pkg::geu: taken = (rs1_data >= rs2_data);
      default:     taken = 1'b0;
    endcase
  end

  // ecall parks the pc on itself until the halt level takes over
  always_comb begin
    if (dec.halt_req) begin
      next_pc = pc;
    end else if (taken) begin
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  assign wb_en = dec.reg_write && (dec.rd != '0);
  assign halt_req = dec.halt_req;

endmodule

//--- logic/commit_stage.sv
module commit_stage (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  input  rv_pkg::reg_idx_t rd,
  input  logic             wb_en,
  input  rv_pkg::word_t    wb_value,
  input  logic             halt_req,
  output logic             halt,
  output rv_pkg::retire_t  retire
);

  logic ecall_retired;

  // the ecall record is on the output this cycle
  assign ecall_retired = retire.valid && retire.halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
      retire.valid <= 1'b0;
      retire.halt <= 1'b0;
    end else begin
      halt <= halt || ecall_retired;
      // the parked ecall is fetched again and must not retire twice
      retire.valid <= !halt && !ecall_retired;
      retire.halt <= halt_req;
      retire.pc <= pc;
      retire.insn <= insn;
      retire.rd <= rd;
      retire.reg_write <= wb_en;
      retire.value <= wb_value;
    end
  end

  no_retire_when_halted_a: assert property (
    @(posedge clk) disable iff (rst)
    halt |-> !retire.valid
  ) else $error("retire strobe while halted");

endmodule

//--- logic/rv_core.sv
module rv_core (
  input  logic            clk,
  input  logic            rst,
  output logic            halt,
  output rv_pkg::retire_t retire
);

  rv_pkg::word_t    pc;
  rv_pkg::word_t    insn;
  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    wb_value;
  logic             wb_en;
  logic             halt_req;

  fetch_unit fetch_i (
    .clk(clk), .rst(rst), .next_pc(next_pc), .halt(halt), .pc(pc), .insn(insn)
  );

  insn_decoder decode_i (.insn(insn), .dec(dec));

  reg_file regs_i (
    .clk(clk), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rd(dec.rd), .wb_en(wb_en), .wb_value(wb_value)
  );

  exec_unit exec_i (
    .pc(pc), .dec(dec), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .next_pc(next_pc), .wb_en(wb_en), .wb_value(wb_value), .halt_req(halt_req)
  );

  commit_stage commit_i (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn), .rd(dec.rd), .wb_en(wb_en),
    .wb_value(wb_value), .halt_req(halt_req), .halt(halt), .retire(retire)
  );

endmodule

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// immediates rebuilt from the raw encoding
function automatic rv_pkg::word_t i_type_imm(input rv_pkg::word_t insn);
  return {{20{insn[31]}}, insn[31:20]};
endfunction

function automatic rv_pkg::word_t b_type_imm(input rv_pkg::word_t insn);
  return {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
endfunction

// register result of lui, op-imm and op
// other opcodes give zero
function automatic rv_pkg::word_t alu_result(input rv_pkg::word_t insn,
                                             input rv_pkg::word_t a,
                                             input rv_pkg::word_t rs2_val);
  rv_pkg::word_t b;
  logic [4:0] sh;
  logic is_op;
  is_op = (insn[6:0] == 7'h33);
  b = is_op ? rs2_val : i_type_imm(insn);
  sh = b[4:0];
  if (insn[6:0] == 7'h37) begin
    return {insn[31:12], 12'h000};
  end
  if (insn[6:0] != 7'h13 && !is_op) begin
    return '0;
  end
  case (insn[14:12])
    3'd0: return (is_op && insn[30]) ? a - b : a + b;
    3'd1: return a << sh;
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return insn[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic writes_rd(input rv_pkg::word_t insn);
  logic writer;
  writer = (insn[6:0] == 7'h37) || (insn[6:0] == 7'h13) || (insn[6:0] == 7'h33);
  return writer && (insn[11:7] != 5'd0);
endfunction

function automatic rv_pkg::word_t next_pc_of(input rv_pkg::word_t pc,
                                             input rv_pkg::word_t insn,
                                             input rv_pkg::word_t a,
                                             input rv_pkg::word_t b);
  logic taken;
  case (insn[14:12])
    3'd0: taken = (a == b);
    3'd1: taken = (a != b);
    3'd4: taken = ($signed(a) < $signed(b));
    3'd5: taken = ($signed(a) >= $signed(b));
    3'd6: taken = (a < b);
    3'd7: taken = (a >= b);
    default: taken = 1'b0;
  endcase
  if (insn[6:0] == 7'h63 && taken) begin
    return pc + b_type_imm(insn);
  end
  return pc + 32'd4;
endfunction

`endif

//--- sim/tb_rv_core.sv
module tb_rv_core;

  localparam int prog_words = 43;
  localparam int cycle_limit = 4 * prog_words + 20;

  logic clk;
  logic rst;
  logic halt;
  rv_pkg::retire_t retire;

  int errors = 0;
  int cycles = 0;
  int retired;

  // architectural model state
  rv_pkg::word_t m_rom [rv_pkg::imem_words];
  rv_pkg::word_t m_regs [32];
  rv_pkg::word_t m_pc;
  logic ecall_seen;

  rv_pkg::word_t exp_insn;
  rv_pkg::word_t exp_a;
  rv_pkg::word_t exp_b;
  rv_pkg::word_t exp_value;
  rv_pkg::word_t exp_next_pc;
  rv_pkg::reg_idx_t exp_rd;
  logic exp_we;
  logic exp_halt;

  `include "tb_ref_model.svh"

  rv_core rv_core_i (.clk(clk), .rst(rst), .halt(halt), .retire(retire));

  always #50 clk = ~clk;

  task automatic report_mismatch(input string sig, input rv_pkg::word_t expected,
                                 input rv_pkg::word_t actual);
    errors++;
    $display("Fail at time %0t: %s expected %h, got %h", $time, sig, expected, actual);
  endtask

  task automatic report_event(input string what);
    errors++;
    $display("Error at time %0t: %s", $time, what);
  endtask

  // expected record for the instruction at the model pc
  always_comb begin
    exp_insn = m_rom[m_pc[9:2]];
    exp_rd = exp_insn[11:7];
    exp_a = m_regs[exp_insn[19:15]];
    exp_b = m_regs[exp_insn[24:20]];
    exp_value = alu_result(exp_insn, exp_a, exp_b);
    exp_we = writes_rd(exp_insn);
    exp_halt = (exp_insn == 32'h0000_0073);
    exp_next_pc = next_pc_of(m_pc, exp_insn, exp_a, exp_b);
  end

  // the model steps once per retire strobe
  always @(posedge clk) begin
    if (rst) begin
      m_pc <= rv_pkg::reset_pc;
      ecall_seen <= 1'b0;
      retired <= 0;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
    end else if (retire.valid) begin
      if (exp_we) begin
        m_regs[exp_rd] <= exp_value;
      end
      m_pc <= exp_next_pc;
      retired <= retired + 1;
      if (exp_halt) begin
        ecall_seen <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles <= cycles + 1;
    end
  end

  pc_a: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.pc == m_pc)
    else report_mismatch("retire.pc", $sampled(m_pc), $sampled(retire.pc));

  insn_a: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.insn == exp_insn)
    else report_mismatch("retire.insn", $sampled(exp_insn), $sampled(retire.insn));

  rd_a: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.rd == exp_rd)
    else report_mismatch("retire.rd", 32'($sampled(exp_rd)), 32'($sampled(retire.rd)));

  we_a: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.reg_write == exp_we)
    else report_mismatch("retire.reg_write", 32'($sampled(exp_we)),
                         32'($sampled(retire.reg_write)));

  value_a: assert property (@(posedge clk) disable iff (rst)
    (retire.valid && exp_we) |-> retire.value == exp_value)
    else report_mismatch("retire.value", $sampled(exp_value), $sampled(retire.value));

  halt_bit_a: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> retire.halt == exp_halt)
    else report_mismatch("retire.halt", 32'($sampled(exp_halt)), 32'($sampled(retire.halt)));

  early_halt_a: assert property (@(posedge clk) disable iff (rst)
    !ecall_seen |-> !halt)
    else report_event("halt went high before the ecall retired");

  halt_rise_a: assert property (@(posedge clk) disable iff (rst)
    (retire.valid && retire.halt) |=> halt)
    else report_event("halt did not rise after the ecall retired");

  halt_hold_a: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt)
    else report_event("halt dropped without a reset");

  quiet_a: assert property (@(posedge clk) disable iff (rst)
    halt |-> !retire.valid)
    else report_event("an instruction retired while halted");

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    $readmemh("sim/program.hex", m_rom);
    repeat (2) @(posedge clk);
    #5 rst = 1'b0;
    // run to the cycle limit so the quiet period after halt is watched too
    while (cycles < cycle_limit) begin
      @(posedge clk);
    end
    #5;
    if (!ecall_seen || !halt) begin
      report_event($sformatf("timeout, core did not halt within %0d cycles", cycle_limit));
    end
    $display("errors: %0d, instructions retired: %0d", errors, retired);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim/program.hex
// one 32-bit instruction word per line, from address 0
800000B7
FFB00113
00700193
00112213
00113293
FFF1C313
1001E393
0F017413
00419493
0030D513
4030D593
00310633
403106B3
00319733
003127B3
00313833
003148B3
00315933
403159B3
00316A33
00317AB3
00518013
00300B33
00300B93
FFFB8B93
FE0B9EE3
00318463
00100C13
00310463
00314463
00100C13
00315463
00316463
00317463
00100C13
00319463
0021C463
0021D463
00100C13
0021E463
00100C13
0021F463
00000073

//--- sim.f
+incdir+sim
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/insn_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/commit_stage.sv
logic/rv_core.sv
sim/tb_rv_core.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
TOP        ?= tb_rv_core
RTL_TOP    ?= rv_core
FILE_LIST  ?= sim.f
RTL_FILES  = logic/rv_pkg.sv logic/fetch_unit.sv logic/insn_decoder.sv \
             logic/reg_file.sv logic/exec_unit.sv logic/commit_stage.sv logic/rv_core.sv
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
